//--- src/requant_pkg.sv
package requant_pkg;

  ////////////////////
  // operand and result widths
  ////////////////////

  // accumulated sum, wide packing (one channel)
  typedef logic [23:0] sum_wide_t;
  // accumulated sum, dual packing (two channels)
  typedef logic [15:0] sum_dual_t;
  // per-channel E scale tail
  typedef logic [15:0] scale_t;

  // uniform multiplier operands
  typedef logic [23:0] mult_a_t;
  typedef logic [15:0] mult_b_t;
  // full 24x16 product, no truncation
  typedef logic [39:0] mult_p_t;

  // right shift applied after the multiply
  typedef logic [4:0]  shift_t;
  // unsigned requantized pixel
  typedef logic [7:0]  pixel_t;

  // array packing of the sums
  typedef enum logic {
    MODE_WIDE = 1'b0,
    MODE_DUAL = 1'b1
  } pack_mode_e;

  ////////////////////
  // lane geometry
  ////////////////////

  // pixels per column, per channel
  localparam int PIX_PER_COL = 2;

  // multiplier lanes: two channels worth of pixels for every column
  function automatic int lane_count(input int cols);
    return 2 * PIX_PER_COL * cols;
  endfunction

  // lanes owned by one channel in dual mode
  function automatic int half_lanes(input int cols);
    return PIX_PER_COL * cols;
  endfunction

  // sum bus width, sized by the dual packing (two 16-bit halves)
  function automatic int sum_vec_width(input int cols);
    return lane_count(cols) * $bits(sum_dual_t);
  endfunction

endpackage

//--- src/mult_op_if.sv
`timescale 1ns/1ps

interface mult_op_if
  import requant_pkg::*;
#(
  parameter int COLS = 4
) ();

  localparam int LANES = lane_count(COLS);

  // operand vector is live this cycle
  logic                 valid;
  // shift travels with its operands
  shift_t               shift;
  // per lane sum, zero extended
  mult_a_t [LANES-1:0]  a_vec;
  // per lane E tail
  mult_b_t [LANES-1:0]  b_vec;

  // decode side
  modport src (
    output valid,
    output shift,
    output a_vec,
    output b_vec
  );

  // execute side
  modport dst (
    input  valid,
    input  shift,
    input  a_vec,
    input  b_vec
  );

endinterface

//--- src/scale_operand_mux.sv
`timescale 1ns/1ps

module scale_operand_mux
  import requant_pkg::*;
#(
  parameter int  COLS  = 4,
  localparam int LANES = lane_count(COLS),
  localparam int SUM_W = sum_vec_width(COLS)
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_valid,
  input  pack_mode_e          mode,
  input  shift_t              shift,
  input  scale_t [1:0]        e_set,
  input  logic [SUM_W-1:0]    sum_vector,
  mult_op_if.src              op
);

  // lanes per channel
  localparam int HALF = half_lanes(COLS);
  // field widths inside sum_vector
  localparam int W_W  = $bits(sum_wide_t);
  localparam int D_W  = $bits(sum_dual_t);

  mult_a_t [LANES-1:0] a_nxt;
  mult_b_t [LANES-1:0] b_nxt;

  ////////////////////
  // steering
  ////////////////////

  always_comb begin
    // upper lanes idle unless dual mode fills them
    for (int i = 0; i < LANES; i++) begin
      a_nxt[i] = '0;
      b_nxt[i] = '0;
    end
    for (int i = 0; i < HALF; i++) begin
      // channel 0 always sits in the low lanes with E0
      b_nxt[i] = mult_b_t'(e_set[0]);
      if (mode == MODE_WIDE) begin
        // 24-bit sums packed from bit 0 up
        a_nxt[i] = mult_a_t'(sum_wide_t'(sum_vector[i*W_W +: W_W]));
      end else begin
        // low half of the bus, channel 0
        a_nxt[i] = mult_a_t'(sum_dual_t'(sum_vector[i*D_W +: D_W]));
        // high half of the bus, channel 1 with E1
        a_nxt[HALF+i] = mult_a_t'(sum_dual_t'(sum_vector[(HALF+i)*D_W +: D_W]));
        b_nxt[HALF+i] = mult_b_t'(e_set[1]);
      end
    end
  end

  ////////////////////
  // operand register
  ////////////////////

  // one cycle from in_valid to op.valid
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      op.valid <= 1'b0;
    end else begin
      op.valid <= in_valid;
    end
  end

  // payload only moves on a live item
  always_ff @(posedge clk) begin
    if (in_valid) begin
      op.shift <= shift;
      op.a_vec <= a_nxt;
      op.b_vec <= b_nxt;
    end
  end

  // packing must be known for any accepted item
  a_mode_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    in_valid |-> !$isunknown(mode)
  );

endmodule

//--- src/scale_mult_array.sv
`timescale 1ns/1ps

module scale_mult_array
  import requant_pkg::*;
#(
  parameter int  COLS  = 4,
  localparam int LANES = lane_count(COLS)
) (
  input  logic                clk,
  input  logic                rst_n,
  mult_op_if.dst              op,
  output logic                p_valid,
  output shift_t              p_shift,
  output mult_p_t [LANES-1:0] p_vec
);

  // product width reachable by a 16-bit sum times a 16-bit E
  localparam int DUAL_P_W = $bits(sum_dual_t) + $bits(mult_b_t);
  localparam int A_W      = $bits(mult_a_t);
  localparam int P_W      = $bits(mult_p_t);

  mult_p_t [LANES-1:0] prod;

  ////////////////////
  // multiplier lanes
  ////////////////////

  // unsigned 24x16, operands widened to the product first
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      prod[i] = mult_p_t'(op.a_vec[i]) * mult_p_t'(op.b_vec[i]);
    end
  end

  // valid pipeline, cleared on reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      p_valid <= 1'b0;
    end else begin
      p_valid <= op.valid;
    end
  end

  // product register, loaded with the item
  always_ff @(posedge clk) begin
    if (op.valid) begin
      p_shift <= op.shift;
      p_vec   <= prod;
    end
  end

  ////////////////////
  // product width check
  ////////////////////

  // a 16-bit sum cannot reach the top product byte
  for (genvar i = 0; i < LANES; i++) begin : g_chk
    a_prod_hi_zero: assert property (
      @(posedge clk) disable iff (!rst_n)
      (op.valid && (op.a_vec[i][A_W-1:$bits(sum_dual_t)] == '0))
      |=> (p_vec[i][P_W-1:DUAL_P_W] == '0)
    );
  end

endmodule

//--- src/requant_round_clamp.sv
`timescale 1ns/1ps

module requant_round_clamp
  import requant_pkg::*;
#(
  parameter int  COLS        = 4,
  parameter int  QUEUE_DEPTH = 4,
  parameter int  OUT_CREDITS = 2,
  localparam int LANES       = lane_count(COLS)
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                p_valid,
  input  shift_t              p_shift,
  input  mult_p_t [LANES-1:0] p_vec,
  output logic                in_credit,
  output logic                out_valid,
  output pixel_t [LANES-1:0]  out_data,
  input  logic                out_credit
);

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
  localparam int CRD_W = $clog2(OUT_CREDITS + 1);
  // one spare bit so the rounding add cannot wrap
  localparam int RND_W = $bits(mult_p_t) + 1;

  pixel_t [LANES-1:0] pix_vec;
  pixel_t [LANES-1:0] queue_mem [QUEUE_DEPTH];
  logic   [PTR_W-1:0] wr_ptr;
  logic   [PTR_W-1:0] rd_ptr;
  logic   [CNT_W-1:0] q_count;
  logic   [CRD_W-1:0] dn_credits;
  logic               wr_en;
  logic               pop;

  ////////////////////
  // round and clamp
  ////////////////////

  // round half up, shift, saturate at 255
  function automatic pixel_t requant_pixel(input mult_p_t p, input shift_t s);
    logic [RND_W-1:0] rnd;
    logic [RND_W-1:0] half;
    half = (s != '0) ? (RND_W'(1) << (s - 1'b1)) : '0;
    rnd  = (RND_W'(p) + half) >> s;
    if (|rnd[RND_W-1:$bits(pixel_t)]) begin
      return '1;
    end
    return rnd[$bits(pixel_t)-1:0];
  endfunction

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      pix_vec[i] = requant_pixel(p_vec[i], p_shift);
    end
  end

  ////////////////////
  // output queue
  ////////////////////

  assign wr_en = p_valid;
  // send only with an item queued and a downstream credit in hand
  assign pop   = (q_count != '0) && (dn_credits != '0);

  always_ff @(posedge clk) begin
    if (wr_en) begin
      queue_mem[wr_ptr] <= pix_vec;
    end
  end

  // pointers wrap explicitly, depth need not be a power of two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      q_count <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      q_count <= q_count + CNT_W'(wr_en) - CNT_W'(pop);
    end
  end

  ////////////////////
  // credit handling
  ////////////////////

  // each pop gives back one upstream credit and spends one downstream
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid  <= 1'b0;
      in_credit  <= 1'b0;
      dn_credits <= CRD_W'(OUT_CREDITS);
    end else begin
      out_valid  <= pop;
      in_credit  <= pop;
      dn_credits <= dn_credits - CRD_W'(pop) + CRD_W'(out_credit);
    end
  end

  // head of queue captured on the pop
  always_ff @(posedge clk) begin
    if (pop) begin
      out_data <= queue_mem[rd_ptr];
    end
  end

  // upstream sent without a credit
  a_no_write_full: assert property (
    @(posedge clk) disable iff (!rst_n)
    wr_en |-> (q_count < CNT_W'(QUEUE_DEPTH))
  );

  // receiver returned more credits than it was granted
  a_dn_credit_max: assert property (
    @(posedge clk) disable iff (!rst_n)
    dn_credits <= CRD_W'(OUT_CREDITS)
  );

endmodule

//--- src/requant_top.sv
`timescale 1ns/1ps

module requant_top
  import requant_pkg::*;
#(
  parameter int  COLS        = 4,
  parameter int  QUEUE_DEPTH = 4,
  parameter int  OUT_CREDITS = 2,
  localparam int LANES       = lane_count(COLS),
  localparam int SUM_W       = sum_vec_width(COLS)
) (
  input  logic                          clk,
  input  logic                          rst_n,
  // upstream side
  input  logic                          in_valid,
  input  pack_mode_e                    mode,
  input  shift_t                        shift,
  input  logic [2*$bits(scale_t)-1:0]   e_set,
  input  logic [SUM_W-1:0]              sum_vector,
  output logic                          in_credit,
  // downstream side
  output logic                          out_valid,
  output pixel_t [LANES-1:0]            out_data,
  input  logic                          out_credit
);

  // execute to result, plain product path
  logic                p_valid;
  shift_t              p_shift;
  mult_p_t [LANES-1:0] p_vec;

  // decode to execute
  mult_op_if #(.COLS(COLS)) mult_op ();

  ////////////////////
  // pipeline stages
  ////////////////////

  // stage 1, steer sums and E tails
  scale_operand_mux #(
    .COLS (COLS)
  ) i_scale_operand_mux (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .mode       (mode),
    .shift      (shift),
    .e_set      (e_set),
    .sum_vector (sum_vector),
    .op         (mult_op)
  );

  // stage 2, sum times E
  scale_mult_array #(
    .COLS (COLS)
  ) i_scale_mult_array (
    .clk     (clk),
    .rst_n   (rst_n),
    .op      (mult_op),
    .p_valid (p_valid),
    .p_shift (p_shift),
    .p_vec   (p_vec)
  );

  // stage 3, round, clamp, queue and credits
  requant_round_clamp #(
    .COLS        (COLS),
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
  ) i_requant_round_clamp (
    .clk        (clk),
    .rst_n      (rst_n),
    .p_valid    (p_valid),
    .p_shift    (p_shift),
    .p_vec      (p_vec),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_credit (out_credit)
  );

endmodule

//--- verif/requant_model.svh
`ifndef REQUANT_MODEL_SVH
`define REQUANT_MODEL_SVH

////////////////////
// random source
////////////////////

logic [31:0] lfsr_state = 32'h55c7_0fff;

// one Galois step, one bit out
function automatic logic lfsr_bit();
  logic lsb;
  lsb = lfsr_state[0];
  lfsr_state = lfsr_state >> 1;
  if (lsb) begin
    lfsr_state = lfsr_state ^ 32'h8020_0003;
  end
  return lsb;
endfunction

// n bits, one step each
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v = {v[30:0], lfsr_bit()};
  end
  return v;
endfunction

////////////////////
// reference requant
////////////////////

// product, half-up rounding, clamp to 8 bits
function automatic logic [7:0] ref_pixel(input longint sum, input longint e, input int sh);
  longint p;
  p = sum * e;
  if (sh > 0) begin
    p = p + (64'd1 << (sh - 1));
  end
  p = p >> sh;
  return (p > 255) ? 8'd255 : p[7:0];
endfunction

// expected pixel vectors, oldest first
logic [127:0] exp_q[$];
logic [127:0] exp_head = '0;
int           exp_count = 0;

function automatic void exp_push(input logic [127:0] v);
  exp_q.push_back(v);
  exp_count = exp_q.size();
  exp_head = exp_q[0];
endfunction

function automatic void exp_pop();
  if (exp_q.size() > 0) begin
    void'(exp_q.pop_front());
  end
  exp_count = exp_q.size();
  exp_head = (exp_count > 0) ? exp_q[0] : '0;
endfunction

`endif

//--- verif/requant_tb.sv
`timescale 1ns/1ps

module requant_tb import requant_pkg::*; ();

  `include "requant_model.svh"

  localparam int QDEPTH = 4;
  localparam int OCRED  = 2;

  logic          clk = 1'b0;
  logic          rst_n;
  logic          in_valid;
  pack_mode_e    mode;
  shift_t        shift;
  logic [31:0]   e_set;
  logic [255:0]  sum_vector;
  logic          in_credit;
  logic          out_valid;
  pixel_t [15:0] out_data;
  logic          out_credit = 1'b0;

  int    errors = 0;
  int    up_credits = QDEPTH;
  int    items_sent = 0;
  int    outs_seen = 0;
  int    dn_granted = OCRED;
  int    owed = 0;
  int    gap = 0;
  int    gap_ctr = 0;
  bit    release_en = 1'b1;
  string test_name = "reset";

  requant_top i_requant_top (.*);

  // 40 ns clock
  initial begin
    forever #20 clk = ~clk;
  end

  ////////////////////
  // credit bookkeeping
  ////////////////////

  always @(posedge clk) begin
    if (in_credit) up_credits++;
    if (out_credit) dn_granted++;
    if (out_valid) begin
      outs_seen++;
      owed++;
      exp_pop();
    end
  end

  // receiver hands back one credit per item, optionally slowed down
  always @(negedge clk) begin
    out_credit <= 1'b0;
    if (release_en && owed > 0) begin
      if (gap_ctr >= gap) begin
        out_credit <= 1'b1;
        owed--;
        gap_ctr = 0;
      end else begin
        gap_ctr++;
      end
    end
  end

  ////////////////////
  // checks
  ////////////////////

  // quiet outputs through reset and before any item
  c_reset_quiet: assert property (@(posedge clk)
    (!rst_n || items_sent == 0) |-> (!out_valid && !in_credit))
    else begin
      errors++;
      $display("output or credit active before any item was sent");
    end

  c_data: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> (out_data == exp_head))
    else begin
      errors++;
      $display("ERROR %s expected %h actual %h", test_name,
               $sampled(exp_head), $sampled(out_data));
    end

  c_no_extra: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> (exp_count > 0))
    else begin
      errors++;
      $display("an item came out that was never sent");
    end

  c_dn_credit: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> (outs_seen < dn_granted))
    else begin
      errors++;
      $display("item sent without a downstream credit");
    end

  // one upstream credit per popped item
  c_up_credit: assert property (@(posedge clk) disable iff (!rst_n)
    in_credit == out_valid)
    else begin
      errors++;
      $display("in_credit pulse does not match an item leaving");
    end

  ////////////////////
  // stimulus helpers
  ////////////////////

  task automatic send_item(input pack_mode_e m, input int sh, input logic [15:0] e0,
                           input logic [15:0] e1, input logic [23:0] sums[16]);
    logic [127:0] exp;
    int           t;
    t = 0;
    while (up_credits == 0 && t < 200) begin
      in_valid = 1'b0;
      @(negedge clk);
      t++;
    end
    if (up_credits == 0) begin
      errors++;
      $display("timed out waiting for an upstream credit in %s", test_name);
      return;
    end
    exp = '0;
    sum_vector = '0;
    for (int i = 0; i < 8; i++) begin
      if (m == MODE_WIDE) begin
        sum_vector[i*24 +: 24] = sums[i];
        exp[i*8 +: 8] = ref_pixel(sums[i], e0, sh);
      end else begin
        sum_vector[i*16 +: 16] = sums[i][15:0];
        sum_vector[(i+8)*16 +: 16] = sums[i+8][15:0];
        exp[i*8 +: 8] = ref_pixel(sums[i][15:0], e0, sh);
        exp[(i+8)*8 +: 8] = ref_pixel(sums[i+8][15:0], e1, sh);
      end
    end
    mode = m;
    shift = shift_t'(sh);
    e_set = {e1, e0};
    in_valid = 1'b1;
    exp_push(exp);
    up_credits--;
    items_sent++;
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic send_random(input pack_mode_e m);
    logic [23:0] sums[16];
    logic [15:0] e0;
    logic [15:0] e1;
    int          sh;
    for (int i = 0; i < 16; i++) begin
      sums[i] = 24'(rand_bits(24));
    end
    e0 = 16'(rand_bits(16));
    e1 = 16'(rand_bits(16));
    sh = rand_bits(5);
    send_item(m, sh, e0, e1, sums);
  endtask

  task automatic drain_and_report();
    int t;
    t = 0;
    // queue empty and every consumed item's credit handed back
    while ((exp_count != 0 || owed != 0) && t < 2000) begin
      @(negedge clk);
      t++;
    end
    if (exp_count != 0 || owed != 0) begin
      errors++;
      $display("timed out draining %s, %0d items missing, %0d credits unreturned",
               test_name, exp_count, owed);
    end
    $display("test %s done, errors so far %0d", test_name, errors);
  endtask

  ////////////////////
  // tests
  ////////////////////

  initial begin
    logic [23:0] sums[16];
    rst_n = 1'b0;
    in_valid = 1'b0;
    mode = MODE_WIDE;
    shift = '0;
    e_set = '0;
    sum_vector = '0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    repeat (4) @(negedge clk);
    $display("test %s done, errors so far %0d", test_name, errors);

    test_name = "wide";
    for (int n = 0; n < 6; n++) send_random(MODE_WIDE);
    drain_and_report();

    test_name = "dual";
    for (int n = 0; n < 6; n++) send_random(MODE_DUAL);
    drain_and_report();

    // exact halves, clamp, and shift 0 pass through
    test_name = "round_clamp";
    for (int i = 0; i < 16; i++) begin
      sums[i] = 24'(8 + 16 * i);
    end
    sums[7] = 24'hff_ffff;
    send_item(MODE_WIDE, 4, 16'd1, 16'd0, sums);
    send_item(MODE_DUAL, 4, 16'd1, 16'd3, sums);
    for (int i = 0; i < 16; i++) begin
      sums[i] = 24'(190 + 10 * i);
    end
    send_item(MODE_DUAL, 0, 16'd1, 16'd1, sums);
    send_item(MODE_WIDE, 1, 16'd3, 16'd0, sums);
    drain_and_report();

    // hold credits back, fill the queue, then release slowly
    test_name = "backpressure";
    release_en = 1'b0;
    for (int n = 0; n < QDEPTH + OCRED; n++) send_random(MODE_DUAL);
    repeat (10) @(negedge clk);
    gap = 3;
    release_en = 1'b1;
    drain_and_report();

    test_name = "streaming";
    gap = 0;
    for (int n = 0; n < 20; n++) begin
      send_random((lfsr_bit() == 1'b1) ? MODE_DUAL : MODE_WIDE);
    end
    drain_and_report();

    if (outs_seen != items_sent) begin
      errors++;
      $display("sent %0d items but received %0d", items_sent, outs_seen);
    end
    $display("items %0d, errors %0d", items_sent, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- requant_top.f
+incdir+verif
src/requant_pkg.sv
src/mult_op_if.sv
src/scale_operand_mux.sv
src/scale_mult_array.sv
src/requant_round_clamp.sv
src/requant_top.sv
verif/requant_tb.sv

//--- Makefile
# Verilator flow for the requant back end

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f requant_top.f --top-module requant_tb

obj_dir/requant_sim: requant_top.f src/*.sv verif/*.sv verif/*.svh
	verilator --binary --timing --assert -f requant_top.f \
		--top-module requant_tb -o requant_sim

sim: obj_dir/requant_sim
	./obj_dir/requant_sim | tee sim.log
	@if grep -q "ERRORS FOUND" sim.log; then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "NO ERRORS" sim.log || (echo "simulation incomplete"; exit 1)

clean:
	rm -rf obj_dir sim.log
